//--- design/rv_core_pkg.sv
// --------------------------------------------------
// Shared widths, encodings and bundles of the RV32I
// multicycle core, referenced by scoped name
// --------------------------------------------------
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int ADDR_WIDTH = 24;
    localparam int RESET_ADDR = 0;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [4:0]            reg_idx_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_ARITH  = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_STORE  = 7'b0100011
    } opcode_t;

    // --------------------------------------------------
    // funct3 encodings
    // --------------------------------------------------
    localparam logic [2:0] ADD_SUB = 3'b000;
    localparam logic [2:0] SLL     = 3'b001;
    localparam logic [2:0] SLT     = 3'b010;
    localparam logic [2:0] SLTU    = 3'b011;
    localparam logic [2:0] XOR     = 3'b100;
    localparam logic [2:0] SRL_SRA = 3'b101;
    localparam logic [2:0] OR      = 3'b110;
    localparam logic [2:0] AND     = 3'b111;

    localparam logic [2:0] BEQ     = 3'b000;
    localparam logic [2:0] BNE     = 3'b001;
    localparam logic [2:0] BLT     = 3'b100;
    localparam logic [2:0] BGE     = 3'b101;
    localparam logic [2:0] BLTU    = 3'b110;
    localparam logic [2:0] BGEU    = 3'b111;

    // Only word stores remain
    localparam logic [2:0] SW      = 3'b010;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_WRITEBACK
    } core_state_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] funct3;
        logic [6:0] funct7;
        word_t      imm;
    } decoded_instr_t;

    typedef struct packed {
        logic       valid;
        addr_t      addr;
        word_t      wdata;
        logic [3:0] wmask;
    } store_req_t;

endpackage

`default_nettype wire

//--- design/fetch_unit.sv
// --------------------------------------------------
// Program counter and instruction register, loaded
// by the strobes of the core state machine
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                capture,
    input  logic                advance,
    input  rv_core_pkg::word_t  instr_rdata,
    input  rv_core_pkg::addr_t  next_pc,
    output rv_core_pkg::addr_t  pc,
    output rv_core_pkg::word_t  instr
);

    // PC moves only at the end of writeback
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= rv_core_pkg::addr_t'(rv_core_pkg::RESET_ADDR);
        end else if (advance) begin
            pc <= next_pc;
        end
    end

    // Instruction word taken with the fetch done pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr <= '0;
        end else if (capture) begin
            instr <= instr_rdata;
        end
    end

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
// --------------------------------------------------
// Splits the held instruction into its fields and
// builds the sign-extended immediate of its format
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  rv_core_pkg::word_t           instr,
    output rv_core_pkg::decoded_instr_t  dec
);

    rv_core_pkg::opcode_t opcode;

    rv_core_pkg::word_t imm_i;
    rv_core_pkg::word_t imm_s;
    rv_core_pkg::word_t imm_b;
    rv_core_pkg::word_t imm_u;
    rv_core_pkg::word_t imm_j;

    assign opcode = rv_core_pkg::opcode_t'(instr[6:0]);

    // --------------------------------------------------
    // Immediate formats
    // --------------------------------------------------
    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec.opcode = opcode;
        dec.rd     = instr[11:7];
        dec.funct3 = instr[14:12];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.funct7 = instr[31:25];

        case (opcode)
            rv_core_pkg::OP_STORE:  dec.imm = imm_s;
            rv_core_pkg::OP_BRANCH: dec.imm = imm_b;
            rv_core_pkg::OP_LUI,
            rv_core_pkg::OP_AUIPC:  dec.imm = imm_u;
            rv_core_pkg::OP_JAL:    dec.imm = imm_j;
            // OP_IMM and OP_JALR, register ops ignore it
            default:                dec.imm = imm_i;
        endcase
    end

endmodule

`default_nettype wire

//--- design/barrel_shifter.sv
// --------------------------------------------------
// Five-stage right shifter; left shifts run through
// it with the word bit-reversed on both sides
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter (
    input  rv_core_pkg::word_t  data_in,
    input  logic [4:0]          amount,
    input  logic                left,
    input  logic                arith,
    output rv_core_pkg::word_t  data_out
);

    rv_core_pkg::word_t staged;
    logic               fill;

    always_comb begin
        // Reverse for left shifts so one right shifter serves both
        for (int i = 0; i < 32; i++) begin
            staged[i] = left ? data_in[31-i] : data_in[i];
        end

        // Sign fill only for SRA
        fill = arith && !left && data_in[31];

        if (amount[4]) staged = {{16{fill}}, staged[31:16]};
        if (amount[3]) staged = {{8{fill}}, staged[31:8]};
        if (amount[2]) staged = {{4{fill}}, staged[31:4]};
        if (amount[1]) staged = {{2{fill}}, staged[31:2]};
        if (amount[0]) staged = {fill, staged[31:1]};

        for (int i = 0; i < 32; i++) begin
            data_out[i] = left ? staged[31-i] : staged[i];
        end
    end

endmodule

`default_nettype wire

//--- design/execute_unit.sv
// --------------------------------------------------
// ALU, branch compare, next PC, writeback value and
// the word store request; purely combinational
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  rv_core_pkg::decoded_instr_t  dec,
    input  rv_core_pkg::addr_t           pc,
    input  rv_core_pkg::word_t           rs1_data,
    input  rv_core_pkg::word_t           rs2_data,
    output rv_core_pkg::word_t           rd_data,
    output logic                         rd_we,
    output rv_core_pkg::addr_t           next_pc,
    output rv_core_pkg::store_req_t      store
);

    rv_core_pkg::word_t op_b;
    rv_core_pkg::word_t add_sub;
    rv_core_pkg::word_t shift_out;
    rv_core_pkg::word_t alu_out;
    rv_core_pkg::word_t pc_word;
    rv_core_pkg::word_t pc_plus4_word;
    rv_core_pkg::word_t rs1_plus_imm;
    rv_core_pkg::addr_t pc_plus4;
    rv_core_pkg::addr_t branch_target;

    logic is_arith;
    logic do_sub;
    logic lt;
    logic ltu;
    logic taken;

    assign is_arith = dec.opcode == rv_core_pkg::OP_ARITH;

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    assign op_b    = is_arith ? rs2_data : dec.imm;
    assign do_sub  = is_arith && dec.funct7[5];
    assign add_sub = do_sub ? rs1_data - op_b : rs1_data + op_b;
    assign lt      = $signed(rs1_data) < $signed(op_b);
    assign ltu     = rs1_data < op_b;

    // funct7[5] also selects SRA, for SRAI it sits in imm[10]
    barrel_shifter shifter0 (
        .data_in  (rs1_data),
        .amount   (op_b[4:0]),
        .left     (dec.funct3 == rv_core_pkg::SLL),
        .arith    (dec.funct3 == rv_core_pkg::SRL_SRA && dec.funct7[5]),
        .data_out (shift_out)
    );

    always_comb begin
        case (dec.funct3)
            rv_core_pkg::ADD_SUB: alu_out = add_sub;
            rv_core_pkg::SLL:     alu_out = shift_out;
            rv_core_pkg::SLT:     alu_out = {31'b0, lt};
            rv_core_pkg::SLTU:    alu_out = {31'b0, ltu};
            rv_core_pkg::XOR:     alu_out = rs1_data ^ op_b;
            rv_core_pkg::SRL_SRA: alu_out = shift_out;
            rv_core_pkg::OR:      alu_out = rs1_data | op_b;
            rv_core_pkg::AND:     alu_out = rs1_data & op_b;
            default:              alu_out = add_sub;
        endcase
    end

    // --------------------------------------------------
    // Writeback value
    // --------------------------------------------------
    assign pc_plus4      = pc + rv_core_pkg::addr_t'(4);
    assign pc_word       = rv_core_pkg::word_t'(pc);
    assign pc_plus4_word = rv_core_pkg::word_t'(pc_plus4);

    always_comb begin
        rd_we   = 1'b1;
        rd_data = alu_out;
        case (dec.opcode)
            rv_core_pkg::OP_IMM,
            rv_core_pkg::OP_ARITH: rd_data = alu_out;
            rv_core_pkg::OP_LUI:   rd_data = dec.imm;
            rv_core_pkg::OP_AUIPC: rd_data = pc_word + dec.imm;
            rv_core_pkg::OP_JAL,
            rv_core_pkg::OP_JALR:  rd_data = pc_plus4_word;
            // Branches, stores and unknown opcodes leave rd alone
            default:               rd_we = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // Control flow
    // --------------------------------------------------
    assign rs1_plus_imm  = rs1_data + dec.imm;
    assign branch_target = pc + dec.imm[rv_core_pkg::ADDR_WIDTH-1:0];

    always_comb begin
        case (dec.funct3)
            rv_core_pkg::BEQ:  taken = rs1_data == rs2_data;
            rv_core_pkg::BNE:  taken = rs1_data != rs2_data;
            rv_core_pkg::BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
            rv_core_pkg::BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
            rv_core_pkg::BLTU: taken = rs1_data < rs2_data;
            rv_core_pkg::BGEU: taken = rs1_data >= rs2_data;
            default:           taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            rv_core_pkg::OP_JAL:    next_pc = branch_target;
            rv_core_pkg::OP_JALR:
                next_pc = {rs1_plus_imm[rv_core_pkg::ADDR_WIDTH-1:1], 1'b0};
            rv_core_pkg::OP_BRANCH: next_pc = taken ? branch_target : pc_plus4;
            default:                next_pc = pc_plus4;
        endcase
    end

    // Word store request
    assign store.valid = dec.opcode == rv_core_pkg::OP_STORE
                      && dec.funct3 == rv_core_pkg::SW;
    assign store.addr  = rs1_plus_imm[rv_core_pkg::ADDR_WIDTH-1:0];
    assign store.wdata = rs2_data;
    assign store.wmask = 4'b1111;

endmodule

`default_nettype wire

//--- design/reg_file.sv
// --------------------------------------------------
// 32 x 32 register file, two registered read ports
// and one write port; x0 is hardwired to zero
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   read,
    input  logic                   write,
    input  rv_core_pkg::reg_idx_t  rs1,
    input  rv_core_pkg::reg_idx_t  rs2,
    input  rv_core_pkg::reg_idx_t  rd,
    input  rv_core_pkg::word_t     rd_data,
    output rv_core_pkg::word_t     rs1_data,
    output rv_core_pkg::word_t     rs2_data
);

    rv_core_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (write && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // Operands valid the cycle after read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rs1_data <= '0;
            rs2_data <= '0;
        end else if (read) begin
            rs1_data <= (rs1 == '0) ? '0 : regs[rs1];
            rs2_data <= (rs2 == '0) ? '0 : regs[rs2];
        end
    end

endmodule

`default_nettype wire

//--- design/rv_core.sv
// --------------------------------------------------
// RV32I multicycle core top: instruction-cycle FSM,
// memory port glue and the datapath units
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                clk,
    input  logic                reset,
    output rv_core_pkg::addr_t  instr_addr,
    output logic                instr_fetch,
    input  rv_core_pkg::word_t  instr_rdata,
    input  logic                instr_done,
    output rv_core_pkg::addr_t  data_addr,
    output rv_core_pkg::word_t  data_wdata,
    output logic [3:0]          data_wmask,
    output logic                data_wstrb,
    input  logic                data_done
);

    rv_core_pkg::core_state_t     state;
    rv_core_pkg::core_state_t     state_next;
    rv_core_pkg::addr_t           pc;
    rv_core_pkg::addr_t           next_pc;
    rv_core_pkg::word_t           instr;
    rv_core_pkg::word_t           rs1_data;
    rv_core_pkg::word_t           rs2_data;
    rv_core_pkg::word_t           rd_data;
    rv_core_pkg::decoded_instr_t  dec;
    rv_core_pkg::store_req_t      store;

    logic rd_we;
    logic capture;
    logic advance;

    // --------------------------------------------------
    // Instruction-cycle FSM
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= rv_core_pkg::ST_FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            rv_core_pkg::ST_FETCH:     if (instr_done) state_next = rv_core_pkg::ST_DECODE;
            rv_core_pkg::ST_DECODE:    state_next = rv_core_pkg::ST_EXECUTE;
            // Stores hold here until the data port finishes
            rv_core_pkg::ST_EXECUTE:
                if (!store.valid || data_done) state_next = rv_core_pkg::ST_WRITEBACK;
            rv_core_pkg::ST_WRITEBACK: state_next = rv_core_pkg::ST_FETCH;
            default:                   state_next = rv_core_pkg::ST_FETCH;
        endcase
    end

    assign capture = state == rv_core_pkg::ST_FETCH && instr_done;
    assign advance = state == rv_core_pkg::ST_WRITEBACK;

    // Memory ports
    assign instr_fetch = state == rv_core_pkg::ST_FETCH;
    assign instr_addr  = pc;
    assign data_wstrb  = state == rv_core_pkg::ST_EXECUTE && store.valid;
    assign data_wmask  = data_wstrb ? store.wmask : 4'b0000;
    assign data_addr   = store.addr;
    assign data_wdata  = store.wdata;

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    fetch_unit fetch0 (
        .clk         (clk),
        .reset       (reset),
        .capture     (capture),
        .advance     (advance),
        .instr_rdata (instr_rdata),
        .next_pc     (next_pc),
        .pc          (pc),
        .instr       (instr)
    );

    instr_decoder decoder0 (
        .instr (instr),
        .dec   (dec)
    );

    reg_file regs0 (
        .clk      (clk),
        .reset    (reset),
        .read     (state == rv_core_pkg::ST_DECODE),
        .write    (advance && rd_we),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rd       (dec.rd),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_unit exec0 (
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_data  (rd_data),
        .rd_we    (rd_we),
        .next_pc  (next_pc),
        .store    (store)
    );

endmodule

`default_nettype wire

//--- bench/rv_core_sva.sv
// --------------------------------------------------
// Port protocol assertions bound to rv_core
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_core_sva (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_fetch,
    input  logic                instr_done,
    input  rv_core_pkg::word_t  instr_rdata,
    input  rv_core_pkg::addr_t  data_addr,
    input  rv_core_pkg::word_t  data_wdata,
    input  logic [3:0]          data_wmask,
    input  logic                data_wstrb,
    input  logic                data_done
);

    localparam logic [6:0] STORE_OPCODE = 7'b0100011;

    // Store request holds still until data_done
    store_stable: assert property (@(posedge clk) disable iff (reset)
        data_wstrb && !data_done |=> data_wstrb && $stable(data_addr)
            && $stable(data_wdata) && $stable(data_wmask))
        else $error("store outputs changed while waiting for data_done");

    // Decode, execute, writeback, then the next fetch
    nonstore_turnaround: assert property (@(posedge clk) disable iff (reset)
        instr_fetch && instr_done && instr_rdata[6:0] != STORE_OPCODE
            |=> !instr_fetch ##1 !instr_fetch ##1 !instr_fetch ##1 instr_fetch)
        else $error("instr_fetch did not return 3 cycles after a non-store");

endmodule

bind rv_core rv_core_sva sva0 (
    .clk         (clk),
    .reset       (reset),
    .instr_fetch (instr_fetch),
    .instr_done  (instr_done),
    .instr_rdata (instr_rdata),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_wmask  (data_wmask),
    .data_wstrb  (data_wstrb),
    .data_done   (data_done)
);

`default_nettype wire

//--- bench/rv_core_tb.sv
// --------------------------------------------------
// Runs a hand-assembled program on the core with
// random memory delays and checks every word store
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    typedef struct packed {
        rv_core_pkg::addr_t addr;
        rv_core_pkg::word_t data;
    } store_entry_t;

    localparam int                 WAIT_LIMIT   = 200;
    localparam rv_core_pkg::addr_t SELF_LOOP_PC = 24'h000114;

    // Branch cases: one operand pair that takes, one that falls through
    localparam logic [2:0] BR_F3 [6] = '{rv_core_pkg::BEQ, rv_core_pkg::BNE,
        rv_core_pkg::BLT, rv_core_pkg::BGE, rv_core_pkg::BLTU, rv_core_pkg::BGEU};
    localparam int TAKEN_RS1 [6] = '{1, 1, 2, 1, 1, 2};
    localparam int TAKEN_RS2 [6] = '{1, 2, 1, 2, 2, 1};
    localparam int FALL_RS1  [6] = '{1, 1, 1, 2, 2, 1};
    localparam int FALL_RS2  [6] = '{2, 1, 2, 1, 1, 2};

    logic               clk;
    logic               reset;
    rv_core_pkg::addr_t instr_addr;
    logic               instr_fetch;
    rv_core_pkg::word_t instr_rdata;
    logic               instr_done;
    rv_core_pkg::addr_t data_addr;
    rv_core_pkg::word_t data_wdata;
    logic [3:0]         data_wmask;
    logic               data_wstrb;
    logic               data_done;

    rv_core_pkg::word_t prog [$];
    store_entry_t       expected [$];

    rv_core dut0 (
        .clk         (clk),
        .reset       (reset),
        .instr_addr  (instr_addr),
        .instr_fetch (instr_fetch),
        .instr_rdata (instr_rdata),
        .instr_done  (instr_done),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_wmask  (data_wmask),
        .data_wstrb  (data_wstrb),
        .data_done   (data_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // RV32I instruction encoders
    // --------------------------------------------------
    function automatic rv_core_pkg::word_t alu_i(logic [2:0] f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
    endfunction

    function automatic rv_core_pkg::word_t alu_r(logic [6:0] f7, logic [2:0] f3,
                                                 int rd, int rs1, int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic rv_core_pkg::word_t store_w(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv_core_pkg::word_t branch(logic [2:0] f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv_core_pkg::word_t upper(logic [6:0] opcode, int rd, int imm);
        return {imm[19:0], rd[4:0], opcode};
    endfunction

    function automatic rv_core_pkg::word_t jal(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic rv_core_pkg::word_t jalr(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
    endfunction

    // --------------------------------------------------
    // Failure reporting
    // --------------------------------------------------
    task automatic report_mismatch(string what, rv_core_pkg::word_t got,
                                   rv_core_pkg::word_t want);
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
        $display("TEST FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_run(string reason);
        $display("Run stopped at %0t ns: %s", $time, reason);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic expect_store(rv_core_pkg::addr_t addr, rv_core_pkg::word_t data);
        store_entry_t entry;
        entry.addr = addr;
        entry.data = data;
        expected.push_back(entry);
    endtask

    // x1 = 100, x2 = -7, x4 = 3, x5 = marker; results go through x3
    task automatic load_program();
        prog.push_back(alu_i(rv_core_pkg::ADD_SUB, 1, 0, 100));
        prog.push_back(alu_i(rv_core_pkg::ADD_SUB, 2, 0, -7));
        prog.push_back(alu_r(7'h00, rv_core_pkg::ADD_SUB, 3, 1, 2));
        prog.push_back(store_w(3, 0, 'h400));
        prog.push_back(alu_r(7'h20, rv_core_pkg::ADD_SUB, 3, 1, 2));
        prog.push_back(store_w(3, 0, 'h404));
        prog.push_back(alu_r(7'h00, rv_core_pkg::SLT, 3, 2, 1));
        prog.push_back(store_w(3, 0, 'h408));
        prog.push_back(alu_r(7'h00, rv_core_pkg::SLTU, 3, 2, 1));
        prog.push_back(store_w(3, 0, 'h40C));
        prog.push_back(alu_i(rv_core_pkg::SLTU, 3, 1, -1));
        prog.push_back(store_w(3, 0, 'h410));
        prog.push_back(alu_i(rv_core_pkg::XOR, 3, 1, 'hFF));
        prog.push_back(store_w(3, 0, 'h414));
        prog.push_back(alu_r(7'h00, rv_core_pkg::AND, 3, 1, 2));
        prog.push_back(store_w(3, 0, 'h418));
        prog.push_back(alu_r(7'h00, rv_core_pkg::OR, 3, 1, 2));
        prog.push_back(store_w(3, 0, 'h41C));
        // Shifts by immediate, then by x4
        prog.push_back(alu_i(rv_core_pkg::SLL, 3, 1, 4));
        prog.push_back(store_w(3, 0, 'h420));
        prog.push_back(alu_i(rv_core_pkg::SRL_SRA, 3, 2, 'h401));
        prog.push_back(store_w(3, 0, 'h424));
        prog.push_back(alu_i(rv_core_pkg::SRL_SRA, 3, 2, 28));
        prog.push_back(store_w(3, 0, 'h428));
        prog.push_back(alu_i(rv_core_pkg::ADD_SUB, 4, 0, 3));
        prog.push_back(alu_r(7'h00, rv_core_pkg::SLL, 3, 2, 4));
        prog.push_back(store_w(3, 0, 'h42C));
        prog.push_back(alu_r(7'h20, rv_core_pkg::SRL_SRA, 3, 2, 4));
        prog.push_back(store_w(3, 0, 'h430));
        prog.push_back(alu_r(7'h00, rv_core_pkg::SRL_SRA, 3, 2, 4));
        prog.push_back(store_w(3, 0, 'h434));
        prog.push_back(alu_i(rv_core_pkg::ADD_SUB, 5, 0, 'h7A5));
        // A taken branch skips its marker, a not-taken one lets it through
        for (int k = 0; k < 6; k++) begin
            prog.push_back(branch(BR_F3[k], TAKEN_RS1[k], TAKEN_RS2[k], 8));
            prog.push_back(store_w(5, 0, 'h440 + 8 * k));
            prog.push_back(branch(BR_F3[k], FALL_RS1[k], FALL_RS2[k], 8));
            prog.push_back(store_w(5, 0, 'h444 + 8 * k));
        end
        prog.push_back(upper(7'b0110111, 6, 'h12345));
        prog.push_back(store_w(6, 0, 'h480));
        prog.push_back(upper(7'b0010111, 6, 'h1));
        prog.push_back(store_w(6, 0, 'h484));
        prog.push_back(jal(7, 8));
        prog.push_back(store_w(5, 0, 'h4FC));
        prog.push_back(store_w(7, 0, 'h488));
        prog.push_back(alu_i(rv_core_pkg::ADD_SUB, 8, 0, 256));
        prog.push_back(jalr(9, 8, 9));
        prog.push_back(store_w(5, 0, 'h4F8));
        prog.push_back(store_w(9, 0, 'h48C));
        prog.push_back(alu_r(7'h00, rv_core_pkg::ADD_SUB, 0, 1, 1));
        prog.push_back(store_w(0, 0, 'h490));
        prog.push_back(jal(0, 0));
    endtask

    task automatic load_expected();
        expect_store(24'h000400, 32'h0000005D);
        expect_store(24'h000404, 32'h0000006B);
        expect_store(24'h000408, 32'h00000001);
        expect_store(24'h00040C, 32'h00000000);
        expect_store(24'h000410, 32'h00000001);
        expect_store(24'h000414, 32'h0000009B);
        expect_store(24'h000418, 32'h00000060);
        expect_store(24'h00041C, 32'hFFFFFFFD);
        expect_store(24'h000420, 32'h00000640);
        expect_store(24'h000424, 32'hFFFFFFFC);
        expect_store(24'h000428, 32'h0000000F);
        expect_store(24'h00042C, 32'hFFFFFFC8);
        expect_store(24'h000430, 32'hFFFFFFFF);
        expect_store(24'h000434, 32'h1FFFFFFF);
        expect_store(24'h000444, 32'h000007A5);
        expect_store(24'h00044C, 32'h000007A5);
        expect_store(24'h000454, 32'h000007A5);
        expect_store(24'h00045C, 32'h000007A5);
        expect_store(24'h000464, 32'h000007A5);
        expect_store(24'h00046C, 32'h000007A5);
        expect_store(24'h000480, 32'h12345000);
        expect_store(24'h000484, 32'h000010E8);
        expect_store(24'h000488, 32'h000000F4);
        expect_store(24'h00048C, 32'h00000104);
        expect_store(24'h000490, 32'h00000000);
    endtask

    // --------------------------------------------------
    // Waits, sampled on the rising edge
    // --------------------------------------------------
    task automatic wait_fetch();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            assert (cycles <= WAIT_LIMIT) else abort_run("no instruction fetch request");
        end while (!(instr_fetch && !reset));
    endtask

    task automatic wait_store();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            assert (cycles <= WAIT_LIMIT) else abort_run("expected store never came");
        end while (!data_wstrb);
    endtask

    // Instruction memory with 0 to 3 idle cycles per fetch
    initial begin : instr_model
        int delay;
        int idx;
        forever begin
            wait_fetch();
            delay = int'($urandom_range(3, 0));
            repeat (delay) @(posedge clk);
            idx = int'(instr_addr[rv_core_pkg::ADDR_WIDTH-1:2]);
            assert (idx < prog.size()) else abort_run("fetch outside the program");
            instr_rdata <= prog[idx];
            instr_done  <= 1'b1;
            @(posedge clk);
            instr_done  <= 1'b0;
        end
    end

    // Reset, store checks and the final verdict
    initial begin : main_flow
        int delay;
        int cycles;
        void'($urandom(26));
        reset       <= 1'b1;
        instr_rdata <= '0;
        instr_done  <= 1'b0;
        data_done   <= 1'b0;
        load_program();
        load_expected();

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (instr_addr == rv_core_pkg::addr_t'(rv_core_pkg::RESET_ADDR))
            else report_mismatch("instr_addr after reset", 32'(instr_addr), 32'h0);
        assert (instr_fetch) else abort_run("instr_fetch low after reset");
        assert (!data_wstrb && data_wmask == 4'b0000)
            else abort_run("store strobe or mask active after reset");

        // Data memory with 0 to 4 cycles of back-pressure
        for (int k = 0; k < expected.size(); k++) begin
            wait_store();
            assert (data_addr == expected[k].addr)
                else report_mismatch($sformatf("store %0d address", k),
                                     32'(data_addr), 32'(expected[k].addr));
            assert (data_wdata == expected[k].data)
                else report_mismatch($sformatf("store %0d data", k), data_wdata,
                                     expected[k].data);
            assert (data_wmask == 4'b1111)
                else report_mismatch($sformatf("store %0d mask", k), 32'(data_wmask),
                                     32'hF);
            delay = int'($urandom_range(4, 0));
            repeat (delay) @(posedge clk);
            data_done <= 1'b1;
            @(posedge clk);
            data_done <= 1'b0;
        end

        cycles = 0;
        while (!(instr_fetch && instr_addr == SELF_LOOP_PC)) begin
            @(posedge clk);
            cycles++;
            assert (!data_wstrb) else abort_run("store beyond the expected list");
            assert (cycles <= WAIT_LIMIT) else abort_run("final self-loop never reached");
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
design/rv_core_pkg.sv
design/fetch_unit.sv
design/instr_decoder.sv
design/barrel_shifter.sv
design/execute_unit.sv
design/reg_file.sv
design/rv_core.sv
bench/rv_core_sva.sv
bench/rv_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the RV32I core testbench with Verilator and runs it.
# The exit status is the simulator's own.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
    --top-module rv_core_tb \
    -Mdir obj_dir \
    -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vrv_core_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0
